/* coreTypes.sv */
package coreTypes;

    // core dimensions
    localparam int numLanes = 2;
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs = 32;
    // rs and rt per lane
    localparam int numReadPorts = 2 * numLanes;

    // opcodes, MIPS numbering
    localparam logic [5:0] opR = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opSlti = 6'h0a;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opXori = 6'h0e;
    localparam logic [5:0] opLui = 6'h0f;

    // funct field of R-type
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnNor = 6'h27;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] imm;
    } iTypeT;

    // same instruction word, two field layouts
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWordT;

    typedef struct packed {
        aluOpT aluOp;
        logic useImm;
        logic regWrite;
        logic [regAddrWidth-1:0] dest;
        logic [4:0] shamt;
        logic [dataWidth-1:0] imm32;
    } laneCtrlT;

    typedef struct packed {
        logic valid;
        laneCtrlT ctrl;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
    } laneIssueT;

    typedef struct packed {
        logic write;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0] data;
    } laneResultT;

endpackage

/* instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder import coreTypes::*; (
    input  instrWordT instr,
    output laneCtrlT  ctrl
);

    logic knownOp;

    always_comb begin
        ctrl = '0;
        knownOp = 1'b1;
        ctrl.aluOp = aluAdd;
        ctrl.shamt = instr.rType.shamt;
        // I-type writes rt unless overridden below
        ctrl.dest = instr.iType.rt;
        ctrl.imm32 = {{(dataWidth - 16){instr.iType.imm[15]}}, instr.iType.imm};

        case (instr.rType.opcode)
            opR: begin
                ctrl.dest = instr.rType.rd;
                case (instr.rType.funct)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnXor: ctrl.aluOp = aluXor;
                    fnNor: ctrl.aluOp = aluNor;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSll: ctrl.aluOp = aluSll;
                    fnSrl: ctrl.aluOp = aluSrl;
                    fnSra: ctrl.aluOp = aluSra;
                    default: knownOp = 1'b0;
                endcase
            end
            opAddi: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluAdd;
            end
            opSlti: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluSlt;
            end
            // logical immediates are zero extended
            opAndi: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluAnd;
                ctrl.imm32 = {{(dataWidth - 16){1'b0}}, instr.iType.imm};
            end
            opOri: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluOr;
                ctrl.imm32 = {{(dataWidth - 16){1'b0}}, instr.iType.imm};
            end
            opXori: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluXor;
                ctrl.imm32 = {{(dataWidth - 16){1'b0}}, instr.iType.imm};
            end
            opLui: begin
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluLui;
                ctrl.imm32 = {{(dataWidth - 16){1'b0}}, instr.iType.imm};
            end
            default: knownOp = 1'b0;
        endcase

        // no write for unknown ops or r0
        ctrl.regWrite = knownOp && (ctrl.dest != '0);
    end

endmodule

/* registerFile.sv */
`timescale 1ns/100ps

module registerFile import coreTypes::*; (
    input  logic clk,
    input  logic arstN,
    input  logic [numReadPorts-1:0][regAddrWidth-1:0] readAddr,
    output logic [numReadPorts-1:0][dataWidth-1:0]    readData,
    input  logic [numLanes-1:0]                       we,
    input  logic [numLanes-1:0][regAddrWidth-1:0]     writeAddr,
    input  logic [numLanes-1:0][dataWidth-1:0]        writeData
);

    logic [dataWidth-1:0] regs [numRegs];

    // write ports never collide, see writebackStage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < numRegs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < numLanes; w++) begin
                if (we[w] && writeAddr[w] != '0) begin
                    regs[writeAddr[w]] <= writeData[w];
                end
            end
        end
    end

    // r0 reads as zero
    always_comb begin
        for (int p = 0; p < numReadPorts; p++) begin
            if (readAddr[p] == '0) begin
                readData[p] = '0;
            end else begin
                readData[p] = regs[readAddr[p]];
            end
        end
    end

endmodule

/* issueStage.sv */
`timescale 1ns/100ps

module issueStage import coreTypes::*; (
    input  logic clk,
    input  logic arstN,
    input  logic issueValid,
    input  instrWordT [numLanes-1:0] instrPair,
    output logic [numReadPorts-1:0][regAddrWidth-1:0] readAddr,
    input  logic [numReadPorts-1:0][dataWidth-1:0] readData,
    input  laneResultT [numLanes-1:0] aluResult,
    output laneIssueT [numLanes-1:0] laneIssue
);

    instrWordT [numLanes-1:0] pairQ;
    logic pairValid;
    laneCtrlT [numLanes-1:0] ctrl;

    // bypass from the pair now in execute, higher lane wins
    function automatic logic [dataWidth-1:0] forwardOperand(
        input logic [regAddrWidth-1:0] addr,
        input logic [dataWidth-1:0] rfData,
        input laneResultT [numLanes-1:0] exResult
    );
        logic [dataWidth-1:0] value;
        value = rfData;
        for (int l = 0; l < numLanes; l++) begin
            if (exResult[l].write && exResult[l].dest == addr && addr != '0) begin
                value = exResult[l].data;
            end
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pairValid <= 1'b0;
        end else begin
            pairValid <= issueValid;
        end
    end

    // instruction words only move on a strobe
    always_ff @(posedge clk) begin
        if (issueValid) begin
            pairQ <= instrPair;
        end
    end

    genvar i;
    generate
        for (i = 0; i < numLanes; i++) begin : genLaneIssue
            instrDecoder u_instrDecoder (
                .instr (pairQ[i]),
                .ctrl  (ctrl[i])
            );

            // port 2i is rs, port 2i+1 is rt
            assign readAddr[2*i]   = pairQ[i].rType.rs;
            assign readAddr[2*i+1] = pairQ[i].rType.rt;

            // lanes of one pair see no results from each other
            always_comb begin
                laneIssue[i].valid = pairValid;
                laneIssue[i].ctrl = ctrl[i];
                laneIssue[i].opA = forwardOperand(readAddr[2*i], readData[2*i], aluResult);
                laneIssue[i].opB = forwardOperand(readAddr[2*i+1], readData[2*i+1],
                                                  aluResult);
            end
        end
    endgenerate

endmodule

/* aluLane.sv */
`timescale 1ns/100ps

module aluLane import coreTypes::*; (
    input  logic clk,
    input  logic arstN,
    input  laneIssueT laneIssue,
    output laneResultT aluResult
);

    logic validQ;
    laneCtrlT ctrlQ;
    logic [dataWidth-1:0] opAQ;
    logic [dataWidth-1:0] opBQ;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] result;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= laneIssue.valid;
        end
    end

    always_ff @(posedge clk) begin
        ctrlQ <= laneIssue.ctrl;
        opAQ <= laneIssue.opA;
        opBQ <= laneIssue.opB;
    end

    assign operandB = ctrlQ.useImm ? ctrlQ.imm32 : opBQ;

    always_comb begin
        case (ctrlQ.aluOp)
            aluAdd: result = opAQ + operandB;
            aluSub: result = opAQ - operandB;
            aluAnd: result = opAQ & operandB;
            aluOr: result = opAQ | operandB;
            aluXor: result = opAQ ^ operandB;
            aluNor: result = ~(opAQ | operandB);
            aluSlt: result = {{(dataWidth - 1){1'b0}}, $signed(opAQ) < $signed(operandB)};
            // shifts act on rt by shamt
            aluSll: result = operandB << ctrlQ.shamt;
            aluSrl: result = operandB >> ctrlQ.shamt;
            aluSra: result = $signed(operandB) >>> ctrlQ.shamt;
            aluLui: result = ctrlQ.imm32 << 16;
            default: result = '0;
        endcase
    end

    assign aluResult.write = validQ & ctrlQ.regWrite;
    assign aluResult.dest = ctrlQ.dest;
    assign aluResult.data = result;

endmodule

/* writebackStage.sv */
`timescale 1ns/100ps

module writebackStage import coreTypes::*; (
    input  logic clk,
    input  logic arstN,
    input  laneResultT [numLanes-1:0] aluResult,
    output laneResultT [numLanes-1:0] wbResult,
    output logic [numLanes-1:0] we,
    output logic [numLanes-1:0][regAddrWidth-1:0] writeAddr,
    output logic [numLanes-1:0][dataWidth-1:0] writeData
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbResult <= '0;
        end else begin
            wbResult <= aluResult;
        end
    end

    // file is written on the same edge that loads wbResult
    always_comb begin
        for (int l = 0; l < numLanes; l++) begin
            we[l] = aluResult[l].write;
            writeAddr[l] = aluResult[l].dest;
            writeData[l] = aluResult[l].data;
        end
        // a later lane to the same register wins
        for (int l = 0; l < numLanes; l++) begin
            for (int h = l + 1; h < numLanes; h++) begin
                if (aluResult[h].write && aluResult[h].dest == aluResult[l].dest) begin
                    we[l] = 1'b0;
                end
            end
        end
    end

endmodule

/* dualIssueCore.sv */
`timescale 1ns/100ps

module dualIssueCore import coreTypes::*; (
    input  logic clk,
    input  logic arstN,
    input  logic issueValid,
    input  instrWordT [numLanes-1:0] instrPair,
    output laneResultT [numLanes-1:0] wbResult
);

    logic [numReadPorts-1:0][regAddrWidth-1:0] readAddr;
    logic [numReadPorts-1:0][dataWidth-1:0] readData;
    laneIssueT [numLanes-1:0] laneIssue;
    laneResultT [numLanes-1:0] aluResult;
    logic [numLanes-1:0] we;
    logic [numLanes-1:0][regAddrWidth-1:0] writeAddr;
    logic [numLanes-1:0][dataWidth-1:0] writeData;

    issueStage u_issueStage (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .instrPair  (instrPair),
        .readAddr   (readAddr),
        .readData   (readData),
        .aluResult  (aluResult),
        .laneIssue  (laneIssue)
    );

    // one execute lane per issue slot
    genvar i;
    generate
        for (i = 0; i < numLanes; i++) begin : genLane
            aluLane u_aluLane (
                .clk       (clk),
                .arstN     (arstN),
                .laneIssue (laneIssue[i]),
                .aluResult (aluResult[i])
            );
        end
    endgenerate

    writebackStage u_writebackStage (
        .clk       (clk),
        .arstN     (arstN),
        .aluResult (aluResult),
        .wbResult  (wbResult),
        .we        (we),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    registerFile u_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .readAddr  (readAddr),
        .readData  (readData),
        .we        (we),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

endmodule

/* tbDualIssueCore.sv */
`timescale 1ns/100ps

module tbDualIssueCore import coreTypes::*; ;

    localparam int maxPairs = 64;
    localparam int drainLimit = 16;

    logic clk;
    logic arstN;
    logic issueValid;
    instrWordT [numLanes-1:0] instrPair;
    laneResultT [numLanes-1:0] wbResult;

    // trace contents
    logic issueChain [maxPairs];
    instrWordT [numLanes-1:0] issueWords [maxPairs];
    laneResultT expPair [maxPairs][numLanes];
    int numPairs;

    // records in flight, due at a given rising edge count
    int dueQ [$];
    laneResultT expQ [$];

    int cycle;
    int errors;
    int timeouts;
    int checks;
    int unsigned seed;

    dualIssueCore u_dualIssueCore (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .instrPair  (instrPair),
        .wbResult   (wbResult)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function int unsigned nextRandom();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    task automatic loadTrace();
        int fd;
        int code;
        int ch;
        int chainVal;
        int lane;
        int wr;
        int dest;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] data;
        numPairs = 0;
        fd = $fopen("dualIssueTrace.txt", "r");
        if (fd == 0) begin
            $display("trace file dualIssueTrace.txt could not be opened");
            errors++;
            return;
        end
        code = $fscanf(fd, " %c", ch);
        while (code == 1) begin
            if (ch == "#") begin
                // rest of a comment line
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "I" && numPairs < maxPairs) begin
                code = $fscanf(fd, "%d %h %h", chainVal, w0, w1);
                issueChain[numPairs] = chainVal[0];
                issueWords[numPairs][0] = w0;
                issueWords[numPairs][1] = w1;
                numPairs++;
            end else if (ch == "E" && numPairs > 0) begin
                code = $fscanf(fd, "%d %d %d %h", lane, wr, dest, data);
                expPair[numPairs-1][lane].write = wr[0];
                expPair[numPairs-1][lane].dest = dest[regAddrWidth-1:0];
                expPair[numPairs-1][lane].data = data;
            end else begin
                $display("trace holds a line that cannot be read");
                errors++;
            end
            code = $fscanf(fd, " %c", ch);
        end
        $fclose(fd);
    endtask

    task automatic compareLane(input int l, input laneResultT want);
        checks++;
        assert (wbResult[l].write == want.write) else begin
            errors++;
            $display("[ERROR] %0t wbResult[%0d].write got %b expected %b",
                     $time, l, wbResult[l].write, want.write);
        end
        // dest and data only matter for a real write
        if (want.write) begin
            assert (wbResult[l].dest == want.dest) else begin
                errors++;
                $display("[ERROR] %0t wbResult[%0d].dest got %0d expected %0d",
                         $time, l, wbResult[l].dest, want.dest);
            end
            assert (wbResult[l].data == want.data) else begin
                errors++;
                $display("[ERROR] %0t wbResult[%0d].data got %h expected %h",
                         $time, l, wbResult[l].data, want.data);
            end
        end
    endtask

    task automatic checkOutputs();
        laneResultT want;
        if (dueQ.size() > 0 && dueQ[0] == cycle) begin
            for (int l = 0; l < numLanes; l++) begin
                want = expQ.pop_front();
                compareLane(l, want);
            end
            void'(dueQ.pop_front());
        end else begin
            // nothing due, so neither lane may write
            for (int l = 0; l < numLanes; l++) begin
                checks++;
                assert (wbResult[l].write == 1'b0) else begin
                    errors++;
                    $display("[ERROR] %0t wbResult[%0d].write got %b expected 0",
                             $time, l, wbResult[l].write);
                end
            end
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic stepCycle(input logic valid, input instrWordT [numLanes-1:0] words);
        int unsigned r;
        checkOutputs();
        if (valid) begin
            instrPair = words;
            issueValid = 1'b1;
        end else begin
            // junk words must be ignored without the strobe
            r = nextRandom();
            instrPair[0] = r * 32'h9E3779B1;
            instrPair[1] = ~(r * 32'h9E3779B1);
            issueValid = 1'b0;
        end
        @(negedge clk);
    endtask

    initial begin
        int gap;
        int drainWait;
        clk = 1'b0;
        arstN = 1'b0;
        issueValid = 1'b0;
        instrPair = '0;
        cycle = 0;
        errors = 0;
        timeouts = 0;
        checks = 0;
        seed = 71314;
        loadTrace();

        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        for (int p = 0; p < numPairs; p++) begin
            gap = issueChain[p] ? 0 : int'(nextRandom() % 3);
            for (int g = 0; g < gap; g++) begin
                stepCycle(1'b0, '0);
            end
            // captured at the next edge, written back two edges later
            dueQ.push_back(cycle + 1 + 2);
            for (int l = 0; l < numLanes; l++) begin
                expQ.push_back(expPair[p][l]);
            end
            stepCycle(1'b1, issueWords[p]);
        end

        drainWait = 0;
        while (dueQ.size() > 0 && drainWait < drainLimit) begin
            stepCycle(1'b0, '0);
            drainWait++;
        end
        if (dueQ.size() > 0) begin
            timeouts++;
            $display("timed out waiting for %0d pending writeback records", dueQ.size());
        end else begin
            repeat (2) stepCycle(1'b0, '0);
        end

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* dualIssueTrace.txt */
# I chain word0 word1 (chain 1 issues right after the previous pair)
# E lane write dest data (dest and data are checked only when write is 1)
# immediates: addi, lui, ori, xori, andi, slti
I 0 20010005 2002FFFD
E 0 1 1 00000005
E 1 1 2 FFFFFFFD
I 0 3C038000 3404F0F0
E 0 1 3 80000000
E 1 1 4 0000F0F0
I 0 38058001 30468F0F
E 0 1 5 00008001
E 1 1 6 00008F0D
I 0 2847FFFE 28288000
E 0 1 7 00000001
E 1 1 8 00000000
# R-type operations
I 0 00224820 00225022
E 0 1 9 00000002
E 1 1 10 00000008
I 0 00C45824 00856025
E 0 1 11 00008000
E 1 1 12 0000F0F1
I 0 00866826 00237027
E 0 1 13 00007FFD
E 1 1 14 7FFFFFFA
I 0 0061782A 0023802A
E 0 1 15 00000001
E 1 1 16 00000000
I 0 00048900 000397C2
E 0 1 17 000F0F00
E 1 1 18 00000001
I 0 00039903 0002A043
E 0 1 19 F8000000
E 1 1 20 FFFFFFFE
# forwarding and same pair writes
I 0 20150064 201600C8
E 0 1 21 00000064
E 1 1 22 000000C8
I 1 02B6B820 02D5C022
E 0 1 23 0000012C
E 1 1 24 00000064
I 1 20190007 20190009
E 0 1 25 00000007
E 1 1 25 00000009
I 1 233A0000 235B0001
E 0 1 26 00000009
E 1 1 27 00000001
# r0 writes and unknown opcodes
I 1 035BE020 23200005
E 0 1 28 0000000A
E 1 0 0 00000000
I 0 0320E820 FC1E1234
E 0 1 29 00000009
E 1 0 0 00000000
I 1 03C0F825 0000083F
E 0 1 31 00000000
E 1 0 0 00000000
I 0 03A11022 0041182A
E 0 1 2 00000004
E 1 1 3 00000001

/* verilog.f */
coreTypes.sv
instrDecoder.sv
registerFile.sv
issueStage.sv
aluLane.sv
writebackStage.sv
dualIssueCore.sv
tbDualIssueCore.sv
